// ==== control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control (
    input  logic             Clk,
    input  logic             reset,
    input  logic             start,
    datapath_ctrl_if.ctrl_mp dp,
    output logic             mem_we,
    output logic             halted
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic base_rel; // LDR and STR address from a base register.

    assign base_rel = (dp.opcode == op_ldr) || (dp.opcode == op_str);
    assign halted   = (state == st_halted);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= st_halted;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next        = state;
        dp.ld_pc          = 1'b0;
        dp.ld_ir          = 1'b0;
        dp.ld_regf        = 1'b0;
        dp.ld_mdr         = 1'b0;
        dp.ld_mar         = 1'b0;
        dp.ld_ben         = 1'b0;
        dp.clr_pc         = 1'b0;
        dp.pcmux_sel      = pc_inc;
        dp.regfilemux_sel = rf_alu;
        dp.alumux1_sel    = a1_ra;
        dp.alumux2_sel    = a2_rb;
        dp.marmux_sel     = mar_pc;
        dp.mdrmux_sel     = mdr_mem;
        dp.alu_op         = alu_pass_b;
        mem_we            = 1'b0;

        case (state)
            st_halted: begin
                if (start) begin
                    dp.clr_pc  = 1'b1;
                    state_next = st_fetch1;
                end
            end
            ////////////////////
            // fetch and decode
            st_fetch1: begin
                dp.ld_mar  = 1'b1;
                dp.ld_pc   = 1'b1;
                state_next = st_fetch2;
            end
            st_fetch2: begin
                dp.ld_mdr  = 1'b1;
                state_next = st_fetch3;
            end
            st_fetch3: begin
                dp.ld_ir   = 1'b1;
                state_next = st_decode;
            end
            st_decode: begin
                dp.ld_ben = 1'b1;
                case (dp.opcode)
                    op_add, op_and, op_not: state_next = st_alu;
                    op_lea:                 state_next = st_lea;
                    op_br:                  state_next = st_br;
                    op_jmp:                 state_next = st_jmp;
                    op_jsr:                 state_next = st_jsr;
                    op_ld, op_ldr:          state_next = st_ld_addr;
                    op_st, op_str:          state_next = st_st_addr;
                    op_trap:                state_next = st_halted;
                    default:                state_next = st_fetch1; // unsupported opcodes are skipped.
                endcase
            end
            ////////////////////
            // execute
            st_alu: begin
                dp.ld_regf     = 1'b1;
                dp.alumux2_sel = a2_imm5;
                case (dp.opcode)
                    op_and:  dp.alu_op = alu_and;
                    op_not:  dp.alu_op = alu_not;
                    default: dp.alu_op = alu_add;
                endcase
                state_next = st_fetch1;
            end
            st_lea: begin
                dp.ld_regf     = 1'b1;
                dp.alumux1_sel = a1_pc;
                dp.alumux2_sel = a2_off9;
                dp.alu_op      = alu_add;
                state_next     = st_fetch1;
            end
            st_br: begin
                dp.ld_pc       = dp.ben;
                dp.pcmux_sel   = pc_alu;
                dp.alumux1_sel = a1_pc;
                dp.alumux2_sel = a2_off9;
                dp.alu_op      = alu_add;
                state_next     = st_fetch1;
            end
            st_jmp: begin
                dp.ld_pc     = 1'b1;
                dp.pcmux_sel = pc_reg;
                state_next   = st_fetch1;
            end
            st_jsr: begin
                dp.ld_regf        = 1'b1; // R7 gets the already incremented PC.
                dp.regfilemux_sel = rf_pc;
                dp.ld_pc          = 1'b1;
                dp.pcmux_sel      = pc_alu;
                dp.alumux1_sel    = a1_pc;
                dp.alumux2_sel    = a2_off11;
                dp.alu_op         = alu_add;
                state_next        = st_fetch1;
            end
            st_ld_addr, st_st_addr: begin
                dp.ld_mar      = 1'b1;
                dp.marmux_sel  = mar_alu;
                dp.alumux1_sel = base_rel ? a1_ra : a1_pc;
                dp.alumux2_sel = base_rel ? a2_off6 : a2_off9;
                dp.alu_op      = alu_add;
                state_next     = (state == st_ld_addr) ? st_ld_mem : st_st_mem;
            end
            st_ld_mem: begin
                dp.ld_mdr  = 1'b1;
                state_next = st_ld_wb;
            end
            st_ld_wb: begin
                dp.ld_regf        = 1'b1;
                dp.regfilemux_sel = rf_mdr;
                state_next        = st_fetch1;
            end
            st_st_mem: begin
                dp.ld_mdr     = 1'b1;
                dp.mdrmux_sel = mdr_ra;
                state_next    = st_st_write;
            end
            st_st_write: begin
                mem_we     = 1'b1;
                state_next = st_fetch1;
            end
            default: state_next = st_halted;
        endcase
    end

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                  Clk,
    input  logic                  reset,
    datapath_ctrl_if.dp_mp        dp,
    input  lc3_isa_pkg::word_t    mdr_in,
    output lc3_isa_pkg::word_t    mar_out,
    output lc3_isa_pkg::word_t    mdr_out
);
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t pc;
    word_t ir;
    word_t mar;
    word_t mdr;
    logic [2:0] cc;
    logic [2:0] cc_next;
    logic ben_q;

    reg_idx_t dr;
    reg_idx_t sr1;
    reg_idx_t sr2;
    word_t ra;
    word_t rb;

    word_t imm5_sext;
    word_t off6_sext;
    word_t off9_sext;
    word_t off11_sext;

    word_t pcmux_out;
    word_t regfilemux_out;
    word_t marmux_out;
    word_t mdrmux_out;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;

    ////////////////////
    // instruction fields
    assign dp.opcode = opcode_t'(ir[op_lsb +: $bits(opcode_t)]);
    assign dp.ben    = ben_q;

    assign dr  = (dp.opcode == op_jsr) ? link_reg : ir[dr_lsb +: $bits(reg_idx_t)];
    // store data is named in the DR field, so port A reads it while MDR takes RA.
    assign sr1 = (dp.mdrmux_sel == mdr_ra) ? ir[dr_lsb +: $bits(reg_idx_t)]
                                           : ir[sr1_lsb +: $bits(reg_idx_t)];
    assign sr2 = ir[sr2_lsb +: $bits(reg_idx_t)];

    assign imm5_sext  = {{(word_width-imm5_bits){ir[imm5_bits-1]}}, ir[imm5_bits-1:0]};
    assign off6_sext  = {{(word_width-off6_bits){ir[off6_bits-1]}}, ir[off6_bits-1:0]};
    assign off9_sext  = {{(word_width-off9_bits){ir[off9_bits-1]}}, ir[off9_bits-1:0]};
    assign off11_sext = {{(word_width-off11_bits){ir[off11_bits-1]}}, ir[off11_bits-1:0]};

    regfile regfile_i (
        .Clk   (Clk),
        .reset (reset),
        .ld    (dp.ld_regf),
        .dr    (dr),
        .sr1   (sr1),
        .sr2   (sr2),
        .wdata (regfilemux_out),
        .ra    (ra),
        .rb    (rb)
    );

    ////////////////////
    // ALU and multiplexers
    always_comb begin
        alu_a = (dp.alumux1_sel == a1_pc) ? pc : ra;

        case (dp.alumux2_sel)
            a2_imm5:  alu_b = ir[imm_flag_bit] ? imm5_sext : rb; // register form if bit 5 is low.
            a2_off9:  alu_b = off9_sext;
            a2_off11: alu_b = off11_sext;
            a2_off6:  alu_b = off6_sext;
            default:  alu_b = rb;
        endcase

        case (dp.alu_op)
            alu_add:    alu_out = alu_a + alu_b;
            alu_and:    alu_out = alu_a & alu_b;
            alu_not:    alu_out = ~alu_a;
            alu_pass_b: alu_out = alu_b;
        endcase

        case (dp.pcmux_sel)
            pc_reg:  pcmux_out = ra;
            pc_alu:  pcmux_out = alu_out;
            default: pcmux_out = pc + 16'd1;
        endcase

        case (dp.regfilemux_sel)
            rf_mdr:  regfilemux_out = mdr;
            rf_pc:   regfilemux_out = pc;
            default: regfilemux_out = alu_out;
        endcase

        marmux_out = (dp.marmux_sel == mar_alu) ? alu_out : pc;
        mdrmux_out = (dp.mdrmux_sel == mdr_ra) ? ra : mdr_in;
    end

    // n, z, p of the value being written back.
    assign cc_next[2] = regfilemux_out[word_width-1];
    assign cc_next[1] = (regfilemux_out == '0);
    assign cc_next[0] = !regfilemux_out[word_width-1] && (regfilemux_out != '0);

    ////////////////////
    // registers
    always_ff @(posedge Clk) begin
        if (reset) begin
            pc    <= '0;
            ir    <= '0;
            mar   <= '0;
            mdr   <= '0;
            cc    <= 3'b010; // a cleared machine reads as zero.
            ben_q <= 1'b0;
        end else begin
            if (dp.clr_pc) begin
                pc <= '0;
            end else if (dp.ld_pc) begin
                pc <= pcmux_out;
            end
            if (dp.ld_ir) ir <= mdr;
            if (dp.ld_mar) mar <= marmux_out;
            if (dp.ld_mdr) mdr <= mdrmux_out;
            if (dp.ld_regf) cc <= cc_next;
            if (dp.ld_ben) begin
                ben_q <= (dp.opcode == op_br) && ((ir[dr_lsb +: 3] & cc) != 3'b000);
            end
        end
    end

    assign mar_out = mar;
    assign mdr_out = mdr;

endmodule

`default_nettype wire

// ==== datapath_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface datapath_ctrl_if;
    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    logic ld_pc;
    logic ld_ir;
    logic ld_regf;
    logic ld_mdr;
    logic ld_mar;
    logic ld_ben;
    logic clr_pc;
    pcmux_t pcmux_sel;
    regfilemux_t regfilemux_sel;
    alumux1_t alumux1_sel;
    alumux2_t alumux2_sel;
    marmux_t marmux_sel;
    mdrmux_t mdrmux_sel;
    alu_op_t alu_op;
    opcode_t opcode;
    logic ben;

    modport ctrl_mp (
        output ld_pc, ld_ir, ld_regf, ld_mdr, ld_mar, ld_ben, clr_pc,
        output pcmux_sel, regfilemux_sel, alumux1_sel, alumux2_sel,
        output marmux_sel, mdrmux_sel, alu_op,
        input  opcode, ben
    );

    modport dp_mp (
        input  ld_pc, ld_ir, ld_regf, ld_mdr, ld_mar, ld_ben, clr_pc,
        input  pcmux_sel, regfilemux_sel, alumux1_sel, alumux2_sel,
        input  marmux_sel, mdrmux_sel, alu_op,
        output opcode, ben
    );

endinterface

`default_nettype wire

// ==== io_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_port (
    input  logic               Clk,
    input  logic               reset,
    input  logic               we,
    input  lc3_isa_pkg::word_t addr,
    input  lc3_isa_pkg::word_t wdata,
    output logic               out_valid,
    output lc3_isa_pkg::word_t out_data
);
    import lc3_isa_pkg::*;

    word_t last_q;

    assign out_valid = we && (addr == io_out_addr);
    assign out_data  = out_valid ? wdata : last_q; // the new value shows in the strobe cycle.

    always_ff @(posedge Clk) begin
        if (reset) begin
            last_q <= '0;
        end else if (out_valid) begin
            last_q <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== lc3_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3_asserts (
    input logic                       Clk,
    input logic                       reset,
    input logic                       start,
    input logic                       mem_we,
    input logic                       halted,
    input logic                       ld_ir,
    input lc3_ctrl_pkg::ctrl_state_t  state
);
    import lc3_ctrl_pkg::*;

    // a halted machine leaves the memory write port to the loader.
    no_store_while_halted: assert property (
        @(posedge Clk) disable iff (reset) halted |-> !mem_we
    ) else $error("mem_we is high while the controller is halted");

    run_begins_on_start: assert property (
        @(posedge Clk) disable iff (reset) $fell(halted) |-> $past(start)
    ) else $error("halted fell without a start strobe in the cycle before");

    ir_loads_in_fetch3: assert property (
        @(posedge Clk) disable iff (reset) ld_ir |-> (state == st_fetch3)
    ) else $error("ld_ir is high outside fetch3");

endmodule

`default_nettype wire

// ==== lc3_ctrl_pkg.sv ====
`default_nettype none

package lc3_ctrl_pkg;

    typedef enum logic [3:0] {
        st_halted,
        st_fetch1,
        st_fetch2,
        st_fetch3,
        st_decode,
        st_alu,      // ADD, AND and NOT.
        st_lea,
        st_br,
        st_jmp,
        st_jsr,
        st_ld_addr,  // LD and LDR.
        st_ld_mem,
        st_ld_wb,
        st_st_addr,  // ST and STR.
        st_st_mem,
        st_st_write
    } ctrl_state_t;

    typedef enum logic [1:0] {pc_inc, pc_reg, pc_alu} pcmux_t;
    typedef enum logic [1:0] {rf_alu, rf_mdr, rf_pc} regfilemux_t;
    typedef enum logic [2:0] {a2_rb, a2_imm5, a2_off9, a2_off11, a2_off6} alumux2_t;
    typedef enum logic {mar_pc, mar_alu} marmux_t;
    typedef enum logic {mdr_mem, mdr_ra} mdrmux_t;
    typedef enum logic {a1_ra, a1_pc} alumux1_t;
    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass_b} alu_op_t;

endpackage

`default_nettype wire

// ==== lc3_golden.txt ====
# P addr data = load strobe, R n = start with at most n instructions
# E value = next expected output, H = wait for halt (all values hex, n decimal)
P 0000 5DA0
P 0001 1DBF
P 0002 1386
P 0003 7380
P 0004 947F
P 0005 7580
P 0006 567D
P 0007 7780
P 0008 E805
P 0009 7980
P 000A 5260
P 000B 1263
P 000C 7380
P 000D 127F
P 000E 03FD
P 000F 0401
P 0010 F025
P 0011 127F
P 0012 0801
P 0013 F025
P 0014 7380
P 0015 2A19
P 0016 7B80
P 0017 3615
P 0018 611F
P 0019 7180
P 001A 791E
P 001B 2010
P 001C 7180
P 001D 4802
P 001E 7F80
P 001F F025
P 0020 1021
P 0021 7180
P 0022 C1C0
P 002F 1234
R 45
P 002F 5555
E FFFE
E 0001
E FFFC
E 000E
E 0003
E 0002
E 0001
E FFFF
E 1234
E FFFC
E 000E
E 000F
E 001E
H
P 0000 14A3
P 0001 7580
P 0002 F025
R 5
E 0004
H
R 5
E 0007
H

// ==== lc3_isa_pkg.sv ====
`default_nettype none

package lc3_isa_pkg;

    localparam int word_width = 16;

    typedef logic [word_width-1:0] word_t;
    typedef logic [2:0] reg_idx_t;

    // only the opcodes this machine executes are named.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    localparam word_t io_out_addr = 16'hFFFF; // stores here go to the output port.

    ////////////////////
    // instruction field positions
    localparam int op_lsb       = 12;
    localparam int dr_lsb       = 9;  // also the nzp field of BR.
    localparam int sr1_lsb      = 6;
    localparam int sr2_lsb      = 0;
    localparam int imm_flag_bit = 5;
    localparam int imm5_bits    = 5;
    localparam int off6_bits    = 6;
    localparam int off9_bits    = 9;
    localparam int off11_bits   = 11;

    localparam reg_idx_t link_reg = 3'd7; // JSR saves the return address here.

endpackage

`default_nettype wire

// ==== lc3_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3_top #(
    parameter int mem_addr_bits = 16
) (
    input  logic               Clk,
    input  logic               reset,
    input  logic               load_valid,
    input  lc3_isa_pkg::word_t load_addr,
    input  lc3_isa_pkg::word_t load_data,
    input  logic               start,
    output logic               out_valid,
    output lc3_isa_pkg::word_t out_data,
    output logic               halted
);
    import lc3_isa_pkg::*;

    word_t mar;
    word_t mdr;
    word_t mem_rdata;
    logic  mem_we;

    datapath_ctrl_if dp_if ();

    control control_i (
        .Clk    (Clk),
        .reset  (reset),
        .start  (start),
        .dp     (dp_if.ctrl_mp),
        .mem_we (mem_we),
        .halted (halted)
    );

    datapath datapath_i (
        .Clk     (Clk),
        .reset   (reset),
        .dp      (dp_if.dp_mp),
        .mdr_in  (mem_rdata),
        .mar_out (mar),
        .mdr_out (mdr)
    );

    memory #(
        .mem_addr_bits (mem_addr_bits)
    ) memory_i (
        .Clk        (Clk),
        .halted     (halted),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .we         (mem_we),
        .addr       (mar),
        .wdata      (mdr),
        .rdata      (mem_rdata)
    );

    io_port io_port_i (
        .Clk       (Clk),
        .reset     (reset),
        .we        (mem_we),
        .addr      (mar),
        .wdata     (mdr),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory #(
    parameter int mem_addr_bits = 16
) (
    input  logic               Clk,
    input  logic               halted,
    input  logic               load_valid,
    input  lc3_isa_pkg::word_t load_addr,
    input  lc3_isa_pkg::word_t load_data,
    input  logic               we,
    input  lc3_isa_pkg::word_t addr,
    input  lc3_isa_pkg::word_t wdata,
    output lc3_isa_pkg::word_t rdata
);
    import lc3_isa_pkg::*;

    localparam int depth = 2 ** mem_addr_bits;

    word_t mem [depth];

    logic                     wr_en;
    logic [mem_addr_bits-1:0] wr_idx;
    word_t                    wr_data;

    // the loader owns the write port only while the processor is halted.
    always_comb begin
        if (halted) begin
            wr_en   = load_valid;
            wr_idx  = load_addr[mem_addr_bits-1:0];
            wr_data = load_data;
        end else begin
            wr_en   = we && (addr != io_out_addr); // the output port takes that store.
            wr_idx  = addr[mem_addr_bits-1:0];
            wr_data = wdata;
        end
    end

    always_ff @(posedge Clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rdata = mem[addr[mem_addr_bits-1:0]]; // upper address bits wrap.

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  ld,
    input  lc3_isa_pkg::reg_idx_t dr,
    input  lc3_isa_pkg::reg_idx_t sr1,
    input  lc3_isa_pkg::reg_idx_t sr2,
    input  lc3_isa_pkg::word_t    wdata,
    output lc3_isa_pkg::word_t    ra,
    output lc3_isa_pkg::word_t    rb
);
    import lc3_isa_pkg::*;

    localparam int num_regs = 2 ** $bits(reg_idx_t);

    word_t regs [num_regs];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (ld) begin
            regs[dr] <= wdata;
        end
    end

    assign ra = regs[sr1]; // reads see the old value during a write.
    assign rb = regs[sr2];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lc3 testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_lc3 -o sim_lc3
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_lc3 > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

// ==== tb_lc3.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc3;
    import lc3_isa_pkg::*;

    localparam int mem_addr_bits = 10;

    logic  Clk;
    logic  reset;
    logic  load_valid;
    word_t load_addr;
    word_t load_data;
    logic  start;
    logic  out_valid;
    word_t out_data;
    logic  halted;

    logic [7:0] cmd_kind [$]; // one entry per golden line, in file order.
    word_t      cmd_a [$];
    word_t      cmd_b [$];
    word_t      expected [$];
    word_t      last_out;
    int         unexpected;
    int         cycles;
    int         cycle_limit;

    lc3_top #(
        .mem_addr_bits (mem_addr_bits)
    ) lc3_top_i (
        .Clk        (Clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .start      (start),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halted     (halted)
    );

    bind control lc3_asserts lc3_asserts_i (
        .Clk    (Clk),
        .reset  (reset),
        .start  (start),
        .mem_we (mem_we),
        .halted (halted),
        .ld_ir  (dp.ld_ir),
        .state  (state)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    ////////////////////
    // reporting
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: %s is %h, expected %h", name, got, want));
        end
    endtask

    ////////////////////
    // golden file
    task automatic read_golden();
        int               fd;
        int               code;
        int               loads;
        int               sum_n;
        logic [7:0]       tok;
        word_t            a;
        word_t            b;
        logic [8*128-1:0] rest;

        loads = 0;
        sum_n = 0;
        fd = $fopen("lc3_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open lc3_golden.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                a = '0;
                b = '0;
                case (tok)
                    "#": code = $fgets(rest, fd); // comment line.
                    "P": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        loads++;
                    end
                    "R": begin
                        code = $fscanf(fd, "%d", a);
                        sum_n += int'(a);
                    end
                    "E": code = $fscanf(fd, "%h", a);
                    "H": code = 1;
                    default: abort_run("the golden file holds an unknown command");
                endcase
                if (tok != "#") begin
                    cmd_kind.push_back(tok);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 20 + loads + 12 * sum_n;
    endtask

    ////////////////////
    // stimulus tasks run on the falling edge
    task automatic load_word(input word_t addr, input word_t data);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        @(negedge Clk);
        load_valid = 1'b0;
    endtask

    task automatic start_run();
        start = 1'b1;
        @(negedge Clk);
        start = 1'b0;
    endtask

    task automatic wait_halt();
        while (!halted) begin
            @(negedge Clk);
        end
        if (expected.size() != 0) begin
            abort_run("the DUT halted while expected outputs were still missing");
        end
        if (unexpected != 0) begin
            abort_run("the DUT sent an output that the golden file does not expect");
        end
        check("out_data", out_data, last_out); // the port holds the last value between strobes.
    endtask

    // outputs are compared in the order they occur.
    always @(posedge Clk) begin
        if (!reset && out_valid) begin
            if (expected.size() == 0) begin
                unexpected++;
            end else begin
                last_out = expected.pop_front();
                check("out_data", out_data, last_out);
            end
        end
    end

    always @(posedge Clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run("timeout: the DUT did not finish within the cycle limit");
        end
    end

    initial begin
        reset       = 1'b1;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        last_out    = '0;
        unexpected  = 0;
        cycles      = 0;
        cycle_limit = 100;
        read_golden();
        repeat (4) @(negedge Clk);
        reset = 1'b0;
        @(negedge Clk);
        check("halted", {15'd0, halted}, 16'd1);
        check("out_valid", {15'd0, out_valid}, 16'd0);
        for (int i = 0; i < cmd_kind.size(); i++) begin
            case (cmd_kind[i])
                "P":     load_word(cmd_a[i], cmd_b[i]);
                "R":     start_run();
                "E":     expected.push_back(cmd_a[i]);
                default: wait_halt();
            endcase
        end
        if (expected.size() != 0 || unexpected != 0) begin
            abort_run("the run ended with outputs missing or unexpected");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
lc3_isa_pkg.sv
lc3_ctrl_pkg.sv
datapath_ctrl_if.sv
regfile.sv
datapath.sv
control.sv
memory.sv
io_port.sv
lc3_top.sv
lc3_asserts.sv
tb_lc3.sv
